// File: common/alu_pkg.sv
package alu_pkg;

        // Operand and result width of the core
        localparam int xlen = 32;

        // Multiplier stages between start and done
        localparam int mul_latency = 2;

        // Divider cycles from start to done: load, 32 steps, then sign fix
        localparam int div_latency = 33;

        // Opcodes follow the ALU select encoding of the core
        typedef enum logic [4:0] {
                op_add    = 5'd0,
                op_sll    = 5'd1,
                op_slt    = 5'd2,
                op_sltu   = 5'd3,
                op_xor    = 5'd4,
                op_srl    = 5'd5,
                op_or     = 5'd6,
                op_and    = 5'd7,
                op_mul    = 5'd8,
                op_mulh   = 5'd9,
                op_mulhsu = 5'd10,
                op_mulhu  = 5'd11,
                op_div    = 5'd12,
                op_divu   = 5'd13,
                op_rem    = 5'd14,
                op_remu   = 5'd15,
                op_sub    = 5'd16,
                op_sra    = 5'd21,
                op_fwd    = 5'd24
        } alu_op_e;

        typedef struct packed {
                alu_op_e         op;
                logic [xlen-1:0] data1;
                logic [xlen-1:0] data2;
        } exec_req_t;

        // Operand compares, independent of the opcode
        typedef struct packed {
                logic zero;
                logic sign;
                logic sltu;
        } exec_flags_t;

        typedef struct packed {
                logic [xlen-1:0] result;
                exec_flags_t     flags;
        } exec_rsp_t;

        function automatic logic is_mul_op(alu_op_e op);
                return op inside {op_mul, op_mulh, op_mulhsu, op_mulhu};
        endfunction

        function automatic logic is_div_op(alu_op_e op);
                return op inside {op_div, op_divu, op_rem, op_remu};
        endfunction

endpackage

// File: hw/alu.sv
`timescale 1ns/1ps

module alu import alu_pkg::*; (
        input  exec_req_t       req,
        output logic [xlen-1:0] result,
        output exec_flags_t     flags
);

        logic [4:0]    shamt;
        logic [xlen:0] diff_s;
        logic [xlen:0] diff_u;
        logic          slt_bit;
        logic          sltu_bit;

        assign shamt = req.data2[4:0];

        // One extra bit so the top bit is the true sign of the difference
        assign diff_s = {req.data1[xlen-1], req.data1} - {req.data2[xlen-1], req.data2};
        assign diff_u = {1'b0, req.data1} - {1'b0, req.data2};

        assign slt_bit = diff_s[xlen];
        assign sltu_bit = diff_u[xlen];

        always_comb begin
                case (req.op)
                op_add: begin
                        result = req.data1 + req.data2;
                end
                op_sub: begin
                        result = diff_u[xlen-1:0];
                end
                op_sll: begin
                        result = req.data1 << shamt;
                end
                op_srl: begin
                        result = req.data1 >> shamt;
                end
                op_sra: begin
                        result = $signed(req.data1) >>> shamt;
                end
                op_slt: begin
                        result = {{(xlen-1){1'b0}}, slt_bit};
                end
                op_sltu: begin
                        result = {{(xlen-1){1'b0}}, sltu_bit};
                end
                op_xor: begin
                        result = req.data1 ^ req.data2;
                end
                op_or: begin
                        result = req.data1 | req.data2;
                end
                op_and: begin
                        result = req.data1 & req.data2;
                end
                op_fwd: begin
                        result = req.data2;
                end
                // Undefined codes, and mul/div which are handled elsewhere
                default: begin
                        result = '0;
                end
                endcase
        end

        // Flags come from a plain compare, not from the subtractor
        always_comb begin
                flags.zero = (req.data1 == req.data2);
                flags.sign = ($signed(req.data1) < $signed(req.data2));
                flags.sltu = (req.data1 < req.data2);
        end

        slt_matches_sign: assert final (req.op != op_slt ||
                result == {{(xlen-1){1'b0}}, flags.sign})
                else $error("SLT result disagrees with sign flag");

endmodule

// File: muldiv/multiplier.sv
`timescale 1ns/1ps

module multiplier import alu_pkg::*; (
        input  logic            clk,
        input  logic            reset,
        input  logic            start,
        input  alu_op_e         op,
        input  logic [xlen-1:0] data1,
        input  logic [xlen-1:0] data2,
        output logic            done,
        output logic [xlen-1:0] result
);

        logic                   sign1;
        logic                   sign2;
        logic                   valid_q;
        alu_op_e                op_q;
        logic signed [xlen:0]   a_q;
        logic signed [xlen:0]   b_q;
        logic signed [2*xlen+1:0] prod;

        // MULH signs both, MULHSU only the first, MUL and MULHU neither
        assign sign1 = (op == op_mulh) || (op == op_mulhsu);
        assign sign2 = (op == op_mulh);

        // Stage one, extended operands
        always_ff @(posedge clk) begin
                if (start) begin
                        a_q <= {sign1 & data1[xlen-1], data1};
                        b_q <= {sign2 & data2[xlen-1], data2};
                        op_q <= op;
                end
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        valid_q <= 1'b0;
                        done <= 1'b0;
                end else begin
                        valid_q <= start;
                        done <= valid_q;
                end
        end

        assign prod = a_q * b_q;

        // Stage two, pick the product word
        always_ff @(posedge clk) begin
                if (valid_q) begin
                        if (op_q == op_mul) begin
                                result <= prod[xlen-1:0];
                        end else begin
                                result <= prod[2*xlen-1:xlen];
                        end
                end
        end

endmodule

// File: muldiv/divider.sv
`timescale 1ns/1ps

module divider import alu_pkg::*; (
        input  logic            clk,
        input  logic            reset,
        input  logic            start,
        input  alu_op_e         op,
        input  logic [xlen-1:0] data1,
        input  logic [xlen-1:0] data2,
        output logic            done,
        output logic            busy,
        output logic [xlen-1:0] result
);

        typedef enum logic [1:0] {
                idle,
                run,
                fix
        } div_state_e;

        div_state_e              state;
        logic [$clog2(xlen)-1:0] count;
        logic [xlen-1:0]         quo;
        logic [xlen-1:0]         rem;
        logic [xlen-1:0]         dvs;
        logic                    neg_q;
        logic                    neg_r;
        logic                    want_rem;
        logic                    is_signed;
        logic                    load;
        logic [xlen:0]           rem_shift;
        logic [xlen:0]           trial;

        assign is_signed = (op == op_div) || (op == op_rem);
        assign load = start && (state == idle);
        assign busy = (state != idle);

        // Next dividend bit shifts in from the top of the quotient register
        assign rem_shift = {rem, quo[xlen-1]};
        assign trial = rem_shift - {1'b0, dvs};

        always_ff @(posedge clk) begin
                if (reset) begin
                        state <= idle;
                        count <= '0;
                        done <= 1'b0;
                end else begin
                        done <= 1'b0;
                        case (state)
                        idle: begin
                                if (start) begin
                                        state <= run;
                                        count <= '0;
                                end
                        end
                        run: begin
                                count <= count + 1'b1;
                                if (&count) begin
                                        state <= fix;
                                        done <= 1'b1;
                                end
                        end
                        fix: begin
                                state <= idle;
                        end
                        default: begin
                                state <= idle;
                        end
                        endcase
                end
        end

        always_ff @(posedge clk) begin
                if (load) begin
                        quo <= (is_signed && data1[xlen-1]) ? -data1 : data1;
                        dvs <= (is_signed && data2[xlen-1]) ? -data2 : data2;
                        rem <= '0;
                        // A zero divisor keeps the all-ones quotient unsigned
                        neg_q <= is_signed && (data1[xlen-1] ^ data2[xlen-1]) && (data2 != '0);
                        neg_r <= is_signed && data1[xlen-1];
                        want_rem <= (op == op_rem) || (op == op_remu);
                end else if (state == run) begin
                        if (!trial[xlen]) begin
                                rem <= trial[xlen-1:0];
                                quo <= {quo[xlen-2:0], 1'b1};
                        end else begin
                                rem <= rem_shift[xlen-1:0];
                                quo <= {quo[xlen-2:0], 1'b0};
                        end
                end
        end

        // Signs applied during the fix cycle
        always_comb begin
                if (want_rem) begin
                        result = neg_r ? -rem : rem;
                end else begin
                        result = neg_q ? -quo : quo;
                end
        end

        done_only_in_fix: assert property (@(posedge clk) disable iff (reset)
                done |-> state == fix)
                else $error("divider done outside fix state");

        div_latency_check: assert property (@(posedge clk) disable iff (reset)
                load |-> ##div_latency done)
                else $error("divider done out of step with start");

endmodule

// File: hw/exec_unit.sv
`timescale 1ns/1ps

module exec_unit import alu_pkg::*; (
        input  logic      clk,
        input  logic      reset,
        input  logic      start,
        input  exec_req_t req,
        output logic      busy,
        output logic      done,
        output exec_rsp_t rsp
);

        typedef enum logic [1:0] {
                idle,
                wait_mul,
                wait_div
        } exec_state_e;

        exec_state_e     state;
        exec_req_t       req_q;
        exec_req_t       cur_req;
        logic            accept;
        logic            mul_start;
        logic            div_start;
        logic            mul_done;
        logic            div_done;
        logic            div_busy;
        logic [xlen-1:0] alu_result;
        logic [xlen-1:0] mul_result;
        logic [xlen-1:0] div_result;
        exec_flags_t     alu_flags;

        assign busy = (state != idle);
        assign accept = start && !busy;

        // New request on the accept edge, the held one while waiting
        assign cur_req = accept ? req : req_q;

        assign mul_start = accept && is_mul_op(req.op);
        assign div_start = accept && is_div_op(req.op);

        always_ff @(posedge clk) begin
                if (accept) begin
                        req_q <= req;
                end
        end

        alu u_alu (
                .req    (cur_req),
                .result (alu_result),
                .flags  (alu_flags)
        );

        multiplier u_multiplier (
                .clk    (clk),
                .reset  (reset),
                .start  (mul_start),
                .op     (cur_req.op),
                .data1  (cur_req.data1),
                .data2  (cur_req.data2),
                .done   (mul_done),
                .result (mul_result)
        );

        divider u_divider (
                .clk    (clk),
                .reset  (reset),
                .start  (div_start),
                .op     (cur_req.op),
                .data1  (cur_req.data1),
                .data2  (cur_req.data2),
                .done   (div_done),
                .busy   (div_busy),
                .result (div_result)
        );

        always_ff @(posedge clk) begin
                if (reset) begin
                        state <= idle;
                        done <= 1'b0;
                        rsp <= '0;
                end else begin
                        done <= 1'b0;
                        case (state)
                        idle: begin
                                if (mul_start) begin
                                        state <= wait_mul;
                                end else if (div_start) begin
                                        state <= wait_div;
                                end else if (accept) begin
                                        rsp <= '{result: alu_result, flags: alu_flags};
                                        done <= 1'b1;
                                end
                        end
                        wait_mul: begin
                                if (mul_done) begin
                                        rsp <= '{result: mul_result, flags: alu_flags};
                                        done <= 1'b1;
                                        state <= idle;
                                end
                        end
                        wait_div: begin
                                if (div_done) begin
                                        rsp <= '{result: div_result, flags: alu_flags};
                                        done <= 1'b1;
                                        state <= idle;
                                end
                        end
                        default: begin
                                state <= idle;
                        end
                        endcase
                end
        end

        no_start_while_busy: assert property (@(posedge clk) disable iff (reset)
                !(start && busy))
                else $warning("start ignored while busy");

        done_is_pulse: assert property (@(posedge clk) disable iff (reset)
                done |=> !done)
                else $error("done high for two cycles");

        one_unit_done: assert property (@(posedge clk) disable iff (reset)
                !(mul_done && div_done))
                else $error("multiplier and divider finished together");

        div_wait_busy: assert property (@(posedge clk) disable iff (reset)
                state == wait_div |-> div_busy)
                else $error("waiting on an idle divider");

endmodule

// File: testbench/exec_unit_ref.svh
`ifndef exec_unit_ref_svh
`define exec_unit_ref_svh

// Expected result of one request, from the RV32IM rules
function automatic logic [31:0] expected_result(input exec_req_t r);
        logic [31:0] a;
        logic [31:0] b;
        logic [63:0] wide_a;
        logic [63:0] wide_b;
        logic [63:0] product;
        a = r.data1;
        b = r.data2;
        // Sign or zero extension to 64 bits, then an exact product
        wide_a = (r.op == op_mulh || r.op == op_mulhsu) ? {{32{a[31]}}, a} : {32'b0, a};
        wide_b = (r.op == op_mulh) ? {{32{b[31]}}, b} : {32'b0, b};
        product = wide_a * wide_b;
        case (r.op)
        op_add: return a + b;
        op_sub: return a - b;
        op_sll: return a << b[4:0];
        op_srl: return a >> b[4:0];
        op_sra: return $signed(a) >>> b[4:0];
        op_slt: return {31'b0, $signed(a) < $signed(b)};
        op_sltu: return {31'b0, a < b};
        op_xor: return a ^ b;
        op_or: return a | b;
        op_and: return a & b;
        op_fwd: return b;
        op_mul: return product[31:0];
        op_mulh, op_mulhsu, op_mulhu: return product[63:32];
        op_div: begin
                if (b == 32'h0) return 32'hffff_ffff;
                if (a == 32'h8000_0000 && b == 32'hffff_ffff) return a;
                return $signed(a) / $signed(b);
        end
        op_rem: begin
                if (b == 32'h0) return a;
                if (a == 32'h8000_0000 && b == 32'hffff_ffff) return 32'h0;
                return $signed(a) % $signed(b);
        end
        op_divu: return (b == 32'h0) ? 32'hffff_ffff : a / b;
        op_remu: return (b == 32'h0) ? a : a % b;
        default: return 32'h0;
        endcase
endfunction

function automatic exec_flags_t expected_flags(input exec_req_t r);
        exec_flags_t f;
        f.zero = (r.data1 == r.data2);
        f.sign = ($signed(r.data1) < $signed(r.data2));
        f.sltu = (r.data1 < r.data2);
        return f;
endfunction

// Cycle of done, with the start edge as cycle 0
function automatic int expected_latency(input alu_op_e op);
        if (op inside {op_mul, op_mulh, op_mulhsu, op_mulhu}) return 3;
        if (op inside {op_div, op_divu, op_rem, op_remu}) return 34;
        return 1;
endfunction

`endif

// File: testbench/exec_unit_tb.sv
`timescale 1ns/1ps

module exec_unit_tb import alu_pkg::*; ();

        `include "exec_unit_ref.svh"

        localparam int busy_timeout = 50;
        localparam int done_timeout = 60;

        // Every defined opcode, and a few undefined ones
        localparam logic [18:0][4:0] op_codes = {5'd0, 5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6,
                5'd7, 5'd8, 5'd9, 5'd10, 5'd11, 5'd12, 5'd13, 5'd14, 5'd15, 5'd16, 5'd21, 5'd24};
        localparam logic [3:0][4:0] bad_codes = {5'd17, 5'd22, 5'd28, 5'd31};
        localparam logic [7:0][31:0] dir_a = {32'haaaa_aaab, 32'h8000_0000, 32'h1234_5678,
                32'hffff_fff9, 32'h0000_0007, 32'h7fff_ffff, 32'h0000_0005, 32'h8000_0000};
        localparam logic [7:0][31:0] dir_b = {32'h0002_fe7d, 32'hffff_ffff, 32'h0000_0000,
                32'h0000_0002, 32'hffff_fffe, 32'hffff_ffe1, 32'h0000_0005, 32'h8000_0000};

        typedef struct packed {
                exec_req_t   req;
                logic [31:0] start_cycle;
        } pending_t;

        logic      clk = 1'b0;
        logic      reset;
        logic      start;
        exec_req_t req;
        logic      busy;
        logic      done;
        exec_rsp_t rsp;
        int        cycle = 0;
        pending_t  pending[$];

        exec_unit u_dut (
                .clk   (clk),
                .reset (reset),
                .start (start),
                .req   (req),
                .busy  (busy),
                .done  (done),
                .rsp   (rsp)
        );

        always #10 clk = ~clk;

        always @(posedge clk) begin
                cycle <= cycle + 1;
        end

        function automatic logic [31:0] xorshift32(input logic [31:0] x);
                logic [31:0] s;
                s = x;
                s = s ^ (s << 13);
                s = s ^ (s >> 17);
                s = s ^ (s << 5);
                return s;
        endfunction

        task automatic fail_run();
                $display("TEST RESULT: FAIL");
                $fatal(1, "simulation stopped after a failure");
        endtask

        task automatic check_value(input string what, input logic [31:0] got,
                                   input logic [31:0] expected);
                if (got !== expected) begin
                        $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got,
                                 expected);
                        fail_run();
                end
        endtask

        // Returns 1 ns after the edge that follows the fall of busy
        task automatic wait_not_busy();
                int waited;
                waited = 0;
                @(negedge clk);
                while (busy) begin
                        waited++;
                        if (waited > busy_timeout) begin
                                $display("Timeout: busy stayed high for %0d cycles", waited);
                                fail_run();
                        end
                        @(negedge clk);
                end
                @(posedge clk);
                #1;
        endtask

        // Called 1 ns after a rising edge
        task automatic send_request(input alu_op_e op, input logic [31:0] a,
                                    input logic [31:0] b, input bit stray);
                pending_t entry;
                entry.req.op = op;
                entry.req.data1 = a;
                entry.req.data2 = b;
                entry.start_cycle = cycle + 1;
                pending.push_back(entry);
                req = entry.req;
                start = 1'b1;
                @(posedge clk);
                #1;
                start = 1'b0;
                // Only multiply and divide hold busy
                check_value("busy after start", busy, expected_latency(op) > 1);
                if (stray) begin
                        // Second start in the middle of a busy period
                        repeat (5) @(posedge clk);
                        #1;
                        req.op = op_add;
                        req.data1 = ~a;
                        start = 1'b1;
                        @(posedge clk);
                        #1;
                        start = 1'b0;
                end
                wait_not_busy();
        endtask

        initial begin : compare
                pending_t entry;
                string    tag;
                int       idle;
                idle = 0;
                forever begin
                        @(negedge clk);
                        if (done) begin
                                idle = 0;
                                if (pending.size() == 0) begin
                                        $display("done pulsed with no request outstanding");
                                        fail_run();
                                end else begin
                                        entry = pending.pop_front();
                                        tag = $sformatf("op %0d a %h b %h", entry.req.op,
                                                        entry.req.data1, entry.req.data2);
                                        check_value({tag, " result"}, rsp.result,
                                                    expected_result(entry.req));
                                        check_value({tag, " flags"}, rsp.flags,
                                                    expected_flags(entry.req));
                                        check_value({tag, " done cycle"},
                                                    cycle - entry.start_cycle + 1,
                                                    expected_latency(entry.req.op));
                                        check_value({tag, " busy at done"}, busy, 0);
                                end
                        end else if (pending.size() != 0) begin
                                idle++;
                                if (idle > done_timeout) begin
                                        $display("Timeout: no done within %0d cycles", idle);
                                        fail_run();
                                end
                        end
                end
        end

        initial begin : stimulus
                logic [31:0] rng;
                logic [31:0] a;
                int          waited;
                reset = 1'b1;
                start = 1'b0;
                req = '0;
                rng = 32'hba37_53ca;
                repeat (3) @(posedge clk);
                #1;
                reset = 1'b0;
                @(negedge clk);
                check_value("done after reset", done, 0);
                check_value("busy after reset", busy, 0);
                check_value("rsp result after reset", rsp.result, 0);
                check_value("rsp flags after reset", rsp.flags, 0);
                @(posedge clk);
                #1;
                // Directed operand pairs through every opcode
                for (int k = 0; k < 19; k++) begin
                        for (int i = 0; i < 8; i++) begin
                                send_request(alu_op_e'(op_codes[k]), dir_a[i], dir_b[i], 1'b0);
                        end
                end
                for (int k = 0; k < 4; k++) begin
                        send_request(alu_op_e'(bad_codes[k]), dir_a[k], dir_b[k], 1'b0);
                end
                send_request(op_div, 32'h8765_4321, 32'h0000_1234, 1'b1);
                for (int n = 0; n < 80; n++) begin
                        rng = xorshift32(rng);
                        a = rng;
                        rng = xorshift32(rng);
                        send_request(alu_op_e'(op_codes[a % 19]), a, rng >> rng[28:24], 1'b0);
                end
                waited = 0;
                while (pending.size() != 0) begin
                        waited++;
                        if (waited > done_timeout) begin
                                $display("Timeout: requests still outstanding at the end");
                                fail_run();
                        end
                        @(negedge clk);
                end
                repeat (3) @(posedge clk);
                $display("TEST RESULT: PASS");
                $finish;
        end

endmodule

// File: list.f
+incdir+testbench
common/alu_pkg.sv
hw/alu.sv
muldiv/multiplier.sv
muldiv/divider.sv
hw/exec_unit.sv
testbench/exec_unit_tb.sv

// File: Bender.yml
package:
  name: exec_unit

sources:
  - common/alu_pkg.sv
  - hw/alu.sv
  - muldiv/multiplier.sv
  - muldiv/divider.sv
  - hw/exec_unit.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/exec_unit_tb.sv
